// File: src/board_pkg.sv
// ##############################
// widths, command codes and bus structs for the board
// GPIO is fixed at one byte
// ##############################

package board_pkg;

  typedef logic [7:0] byte_t;

  // command codes sent as the first byte of a frame
  typedef enum logic [7:0] {
    op_gpio_write = 8'h01,
    op_gpio_read  = 8'h02,
    op_exit       = 8'h03
  } opcode_e;

  // answer for an opcode the engine does not know
  localparam byte_t resp_error = 8'hEE;

  // one received byte, valid is a single-cycle strobe
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_beat_t;

  // one byte to send, start is a single-cycle strobe
  typedef struct packed {
    logic  start;
    byte_t data;
  } tx_req_t;

  // sticky exit report
  typedef struct packed {
    logic  valid;
    byte_t value;
  } exit_t;

endpackage

// File: src/clk_gen_wrapper.sv
// ##############################
// simulation model of the clock wizard, no reset
// CLK_DIV must be even and at least 2
// ##############################
`timescale 1ns/1ps

module clk_gen_wrapper #(
  parameter int unsigned CLK_DIV = 2
) (
  input  logic clk_i,
  output logic clk_gen_o
);

  localparam int unsigned HALF_DIV = CLK_DIV / 2;
  localparam int unsigned CNT_W = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;

  // start values stand in for the wizard's locked output
  logic [CNT_W-1:0] div_cnt = '0;
  logic             clk_q   = 1'b0;

  // toggle every half period of the divided clock
  always_ff @(posedge clk_i) begin
    if (div_cnt == CNT_W'(HALF_DIV - 1)) begin
      div_cnt <= '0;
      clk_q   <= ~clk_q;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign clk_gen_o = clk_q;

endmodule

// File: src/board_status.sv
// ##############################
// rst_i is active high from the pin
// rst_n releases on the 2nd clk_gen edge
// ##############################
`timescale 1ns/1ps

module board_status #(
  parameter int unsigned CLK_LED_COUNT_LENGTH = 24
) (
  input  logic clk_gen_i,
  input  logic rst_i,
  output logic rst_n_o,
  output logic rst_led_o,
  output logic clk_led_o
);

  logic [1:0]                      rst_sync_q;
  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count_q;

  // assert at once, release through two flops
  always_ff @(posedge clk_gen_i or posedge rst_i) begin
    if (rst_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = rst_sync_q[1];

  // LED is lit while the board is out of reset
  assign rst_led_o = rst_n_o;

  // free-running heartbeat
  always_ff @(posedge clk_gen_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  // heartbeat restarts from zero after every reset
  heartbeat_held_in_reset: assert property (
    @(posedge clk_gen_i) !rst_n_o |-> clk_count_q == '0
  ) else $error("heartbeat counter running during reset");

endmodule

// File: src/uart_rx.sv
// ##############################
// 8N1 receiver, BAUD_DIV >= 4
// bad stop bit drops the byte
// ##############################
`timescale 1ns/1ps

module uart_rx #(
  parameter int unsigned BAUD_DIV = 16
) (
  input  logic                clk_gen_i,
  input  logic                rst_n_i,
  input  logic                rx_i,
  output board_pkg::rx_beat_t beat_o
);

  localparam int unsigned CNT_W = $clog2(BAUD_DIV);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e        state_q;
  logic [2:0]       rx_sync_q;
  logic [CNT_W-1:0] baud_cnt_q;
  logic [2:0]       bit_idx_q;
  board_pkg::byte_t shift_q;
  logic             valid_q;
  board_pkg::byte_t data_q;
  logic             rx_s;
  logic             rx_fall;

  assign rx_s    = rx_sync_q[1];
  assign rx_fall = rx_sync_q[2] & ~rx_sync_q[1];

  always_ff @(posedge clk_gen_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_sync_q  <= 3'b111;
      state_q    <= rx_idle;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      valid_q    <= 1'b0;
    end else begin
      rx_sync_q <= {rx_sync_q[1:0], rx_i};
      valid_q   <= 1'b0;
      baud_cnt_q <= baud_cnt_q + 1'b1;
      case (state_q)
        rx_idle: begin
          baud_cnt_q <= '0;
          if (rx_fall) state_q <= rx_start;
        end
        // half a bit in, start bit must still be low
        rx_start: begin
          if (baud_cnt_q == CNT_W'(BAUD_DIV / 2 - 1)) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            state_q    <= rx_s ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (baud_cnt_q == CNT_W'(BAUD_DIV - 1)) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) state_q <= rx_stop;
          end
        end
        rx_stop: begin
          if (baud_cnt_q == CNT_W'(BAUD_DIV - 1)) begin
            valid_q <= rx_s;
            state_q <= rx_idle;
          end
        end
        default: state_q <= rx_idle;
      endcase
    end
  end

  // data path, LSB first
  always_ff @(posedge clk_gen_i) begin
    if (state_q == rx_data && baud_cnt_q == CNT_W'(BAUD_DIV - 1)) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if (state_q == rx_stop) data_q <= shift_q;
  end

  assign beat_o = '{valid: valid_q, data: data_q};

  rx_valid_single: assert property (
    @(posedge clk_gen_i) disable iff (!rst_n_i) beat_o.valid |=> !beat_o.valid
  ) else $error("rx valid held for more than one cycle");

endmodule

// File: src/uart_tx.sv
// ##############################
// 8N1 transmitter, start only when idle
// ##############################
`timescale 1ns/1ps

module uart_tx #(
  parameter int unsigned BAUD_DIV = 16
) (
  input  logic               clk_gen_i,
  input  logic               rst_n_i,
  input  board_pkg::tx_req_t req_i,
  output logic               busy_o,
  output logic               tx_o
);

  localparam int unsigned CNT_W = $clog2(BAUD_DIV);

  logic [9:0]       frame_q;
  logic [CNT_W-1:0] baud_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             busy_q;

  always_ff @(posedge clk_gen_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      frame_q    <= '1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b0;
    end else if (req_i.start) begin
      // stop bit, data, start bit
      frame_q    <= {1'b1, req_i.data, 1'b0};
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b1;
    end else if (busy_q) begin
      if (baud_cnt_q == CNT_W'(BAUD_DIV - 1)) begin
        baud_cnt_q <= '0;
        // ones shift in so the line idles high
        frame_q    <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = frame_q[0];

  tx_start_when_idle: assert property (
    @(posedge clk_gen_i) disable iff (!rst_n_i) req_i.start |-> !busy_o
  ) else $error("tx start while busy");

endmodule

// File: src/cmd_engine.sv
// ##############################
// two-byte frames, opcode then data
// gpio_i read without resync
// ##############################
`timescale 1ns/1ps

module cmd_engine (
  input  logic                clk_gen_i,
  input  logic                rst_n_i,
  input  board_pkg::rx_beat_t beat_i,
  input  logic                tx_busy_i,
  input  board_pkg::byte_t    gpio_i,
  output board_pkg::tx_req_t  tx_req_o,
  output board_pkg::byte_t    gpio_o,
  output board_pkg::exit_t    exit_o
);

  typedef enum logic {
    wait_op,
    wait_data
  } frame_state_e;

  frame_state_e     state_q;
  board_pkg::byte_t op_q;
  logic             pend_q;
  logic             pend_gpio_q;
  board_pkg::byte_t resp_q;
  board_pkg::byte_t gpio_q;
  board_pkg::exit_t exit_q;
  logic             fire;

  // a response waits here until the transmitter is free
  assign fire = pend_q & ~tx_busy_i;

  always_ff @(posedge clk_gen_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= wait_op;
      pend_q      <= 1'b0;
      pend_gpio_q <= 1'b0;
      gpio_q      <= '0;
      exit_q      <= '0;
    end else begin
      if (fire) pend_q <= 1'b0;
      if (beat_i.valid) begin
        if (state_q == wait_op) begin
          state_q <= wait_data;
        end else begin
          state_q <= wait_op;
          case (op_q)
            board_pkg::op_gpio_write: begin
              gpio_q      <= beat_i.data;
              pend_q      <= 1'b1;
              pend_gpio_q <= 1'b0;
            end
            board_pkg::op_gpio_read: begin
              pend_q      <= 1'b1;
              pend_gpio_q <= 1'b1;
            end
            board_pkg::op_exit: begin
              // first report wins
              if (!exit_q.valid) exit_q <= '{valid: 1'b1, value: beat_i.data};
            end
            default: begin
              pend_q      <= 1'b1;
              pend_gpio_q <= 1'b0;
            end
          endcase
        end
      end
    end
  end

  // opcode of the open frame and the byte to answer with
  always_ff @(posedge clk_gen_i) begin
    if (beat_i.valid && state_q == wait_op) op_q <= beat_i.data;
    if (beat_i.valid && state_q == wait_data) begin
      resp_q <= (op_q == board_pkg::op_gpio_write) ? beat_i.data : board_pkg::resp_error;
    end
  end

  assign tx_req_o = '{start: fire, data: pend_gpio_q ? gpio_i : resp_q};
  assign gpio_o   = gpio_q;
  assign exit_o   = exit_q;

  exit_is_sticky: assert property (
    @(posedge clk_gen_i) disable iff (!rst_n_i) exit_o.valid |=> exit_o.valid
  ) else $error("exit valid dropped outside reset");

endmodule

// File: src/board_wrapper.sv
// ##############################
// board top, clock model is sim only
// only bit 0 of the exit value reaches a pin
// ##############################
`timescale 1ns/1ps

module board_wrapper #(
  parameter int unsigned CLK_DIV              = 2,
  parameter int unsigned BAUD_DIV             = 16,
  parameter int unsigned CLK_LED_COUNT_LENGTH = 24
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             uart_rx_i,
  input  board_pkg::byte_t gpio_i,
  output logic             rst_led_o,
  output logic             clk_led_o,
  output logic             clk_out_o,
  output logic             uart_tx_o,
  output board_pkg::byte_t gpio_o,
  output logic             exit_value_o,
  output logic             exit_valid_o
);

  logic                clk_gen;
  logic                rst_n;
  board_pkg::rx_beat_t rx_beat;
  board_pkg::tx_req_t  tx_req;
  logic                tx_busy;
  board_pkg::exit_t    exit_rep;

  clk_gen_wrapper #(
    .CLK_DIV(CLK_DIV)
  ) clk_gen_wrapper_i (
    .clk_i    (clk_i),
    .clk_gen_o(clk_gen)
  );

  board_status #(
    .CLK_LED_COUNT_LENGTH(CLK_LED_COUNT_LENGTH)
  ) board_status_i (
    .clk_gen_i(clk_gen),
    .rst_i    (rst_i),
    .rst_n_o  (rst_n),
    .rst_led_o(rst_led_o),
    .clk_led_o(clk_led_o)
  );

  uart_rx #(
    .BAUD_DIV(BAUD_DIV)
  ) uart_rx_i0 (
    .clk_gen_i(clk_gen),
    .rst_n_i  (rst_n),
    .rx_i     (uart_rx_i),
    .beat_o   (rx_beat)
  );

  uart_tx #(
    .BAUD_DIV(BAUD_DIV)
  ) uart_tx_i0 (
    .clk_gen_i(clk_gen),
    .rst_n_i  (rst_n),
    .req_i    (tx_req),
    .busy_o   (tx_busy),
    .tx_o     (uart_tx_o)
  );

  cmd_engine cmd_engine_i (
    .clk_gen_i(clk_gen),
    .rst_n_i  (rst_n),
    .beat_i   (rx_beat),
    .tx_busy_i(tx_busy),
    .gpio_i   (gpio_i),
    .tx_req_o (tx_req),
    .gpio_o   (gpio_o),
    .exit_o   (exit_rep)
  );

  // clock output for debugging
  assign clk_out_o    = clk_gen;
  assign exit_value_o = exit_rep.value[0];
  assign exit_valid_o = exit_rep.valid;

endmodule

// File: testbench/uart_host.svh
// ##############################
// host side of the UART link, 8N1
// bits are timed on clk_out_o edges
// ##############################
`ifndef UART_HOST_SVH
`define UART_HOST_SVH

// one frame on uart_rx_i, each bit held for BIT_CYCLES edges
task automatic send_byte(input board_pkg::byte_t b);
  logic [9:0] frame;
  frame = {1'b1, b, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(posedge clk_out_o);
    #10;
    uart_rx_i = frame[i];
    repeat (BIT_CYCLES - 1) @(posedge clk_out_o);
  end
endtask

// waits for a start bit, then samples every bit in its middle
task automatic recv_byte(output board_pkg::byte_t b);
  int unsigned waited;
  waited = 0;
  b = '0;
  while (uart_tx_o !== 1'b0) begin
    if (waited == 40 * BIT_CYCLES) begin
      $display("no start bit on uart_tx_o within 40 bit periods");
      end_with_failure();
    end
    step_cycle();
    waited++;
  end
  repeat (BIT_CYCLES / 2) @(posedge clk_out_o);
  #10;
  if (uart_tx_o !== 1'b0) begin
    $display("start bit on uart_tx_o ended before its middle");
    end_with_failure();
  end
  for (int i = 0; i < 8; i++) begin
    repeat (BIT_CYCLES) @(posedge clk_out_o);
    #10;
    b[i] = uart_tx_o;
  end
  repeat (BIT_CYCLES) @(posedge clk_out_o);
  #10;
  if (uart_tx_o !== 1'b1) begin
    $display("stop bit on uart_tx_o is low");
    end_with_failure();
  end
endtask

`endif

// File: testbench/tb_board_wrapper.sv
// ##############################
// directed tests of board_wrapper over UART
// CLK_DIV 2, BAUD_DIV 8, 4-bit heartbeat
// ##############################
`timescale 1ns/1ps

module tb_board_wrapper;

  localparam int unsigned BIT_CYCLES     = 8;
  localparam int unsigned HB_HALF        = 8;
  localparam int unsigned TIMEOUT_CYCLES = 3000;

  logic             clk_i;
  logic             rst_i;
  logic             uart_rx_i;
  board_pkg::byte_t gpio_i;
  logic             rst_led_o;
  logic             clk_led_o;
  logic             clk_out_o;
  logic             uart_tx_o;
  board_pkg::byte_t gpio_o;
  logic             exit_value_o;
  logic             exit_valid_o;

  int unsigned      cycle_count = 0;
  integer           seed;
  board_pkg::byte_t gpio_model;

  board_wrapper #(
    .CLK_DIV(2),
    .BAUD_DIV(BIT_CYCLES),
    .CLK_LED_COUNT_LENGTH(4)
  ) uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .uart_rx_i   (uart_rx_i),
    .gpio_i      (gpio_i),
    .rst_led_o   (rst_led_o),
    .clk_led_o   (clk_led_o),
    .clk_out_o   (clk_out_o),
    .uart_tx_o   (uart_tx_o),
    .gpio_o      (gpio_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish in %0d board cycles", TIMEOUT_CYCLES);
      end_with_failure();
    end
  end

  task automatic check_byte(input string name, input board_pkg::byte_t got,
                            input board_pkg::byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_exit(input string name, input board_pkg::exit_t got,
                            input board_pkg::exit_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got valid 0x%0h value 0x%02h, expected valid 0x%0h value 0x%02h",
               name, got.valid, got.value, exp.valid, exp.value);
      end_with_failure();
    end
  endtask

  // inputs change 10 ns after the clk_gen edge
  task automatic step_cycle();
    @(posedge clk_out_o);
    #10;
  endtask

  `include "uart_host.svh"

  // the response starts before the frame's stop bit is over
  task automatic exchange(input board_pkg::byte_t op, input board_pkg::byte_t data,
                          output board_pkg::byte_t resp);
    board_pkg::byte_t got;
    fork
      begin
        send_byte(op);
        send_byte(data);
      end
      recv_byte(got);
    join
    resp = got;
  endtask

  task automatic test_reset_state();
    check_byte("gpio_o", gpio_o, 8'h00);
    check_level("exit_valid_o", exit_valid_o, 1'b0);
    check_level("uart_tx_o", uart_tx_o, 1'b1);
    check_level("rst_led_o", rst_led_o, 1'b1);
  endtask

  task automatic test_heartbeat();
    logic        prev;
    int unsigned steps;
    prev  = clk_led_o;
    steps = 0;
    while (clk_led_o === prev) begin
      if (steps == 2 * HB_HALF) begin
        $display("clk_led_o never toggled");
        end_with_failure();
      end
      step_cycle();
      steps++;
    end
    prev  = clk_led_o;
    steps = 0;
    while (clk_led_o === prev && steps <= 2 * HB_HALF) begin
      step_cycle();
      steps++;
    end
    check_byte("clk_led_o half period", board_pkg::byte_t'(steps), board_pkg::byte_t'(HB_HALF));
  endtask

  task automatic test_gpio_write();
    board_pkg::byte_t data;
    board_pkg::byte_t echo;
    data = board_pkg::byte_t'($random(seed));
    exchange(board_pkg::op_gpio_write, data, echo);
    gpio_model = data;
    check_byte("gpio_o", gpio_o, gpio_model);
    check_byte("uart_tx_o echo", echo, data);
  endtask

  task automatic test_gpio_read();
    board_pkg::byte_t resp;
    gpio_i = board_pkg::byte_t'($random(seed));
    step_cycle();
    exchange(board_pkg::op_gpio_read, 8'h00, resp);
    check_byte("uart_tx_o read data", resp, gpio_i);
  endtask

  task automatic test_unknown_opcode();
    board_pkg::byte_t resp;
    exchange(8'h7F, board_pkg::byte_t'($random(seed)), resp);
    check_byte("uart_tx_o error code", resp, board_pkg::resp_error);
    check_byte("gpio_o", gpio_o, gpio_model);
  endtask

  task automatic test_exit();
    board_pkg::exit_t exp;
    board_pkg::exit_t got;
    int unsigned      waited;
    exp    = '{valid: 1'b1, value: 8'h01};
    waited = 0;
    send_byte(board_pkg::op_exit);
    send_byte(8'h01);
    step_cycle();
    // no response byte, so wait for the sticky flag itself
    while (exit_valid_o !== 1'b1 && waited < BIT_CYCLES) begin
      step_cycle();
      waited++;
    end
    got = '{valid: exit_valid_o, value: {7'b0, exit_value_o}};
    check_exit("exit", got, exp);
    // exit stays set through later traffic
    test_gpio_write();
    got = '{valid: exit_valid_o, value: {7'b0, exit_value_o}};
    check_exit("exit", got, exp);
  endtask

  initial begin
    seed       = 32'h06a7_6169;
    rst_i      = 1'b1;
    uart_rx_i  = 1'b1;
    gpio_i     = '0;
    gpio_model = '0;
    repeat (2) @(posedge clk_out_o);
    #10;
    check_level("rst_led_o in reset", rst_led_o, 1'b0);
    rst_i = 1'b0;
    repeat (3) step_cycle();
    test_reset_state();
    test_heartbeat();
    test_gpio_write();
    test_gpio_read();
    test_unknown_opcode();
    test_exit();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: mini_board.f
+incdir+testbench
src/board_pkg.sv
src/clk_gen_wrapper.sv
src/board_status.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_engine.sv
src/board_wrapper.sv
testbench/tb_board_wrapper.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board testbench with Verilator.
# The run counts as passed only if the pass message shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_board_wrapper -f mini_board.f

# output goes to stderr for the user and to grep for the verdict
./obj_dir/Vtb_board_wrapper | tee /dev/stderr | grep -q "Verification passed"

echo "simulation run finished"
